/* verilog/core_pkg.sv */
package core_pkg;

  // major opcodes of the supported subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // funct7 values that pick the R-type operation
  localparam logic [6:0] F7_SUB = 7'b0100000;
  localparam logic [6:0] F7_MUL = 7'b0000001;

  // register-register format, also the plain field view
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // immediate format, 12-bit signed immediate
  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // branch format, immediate scattered around rs1/rs2
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  // jump format, 20-bit immediate
  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, four ways to read it
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    b_fmt_t b;
    j_fmt_t j;
  } instr_t;

  // ALU operations, PASS forwards the JAL link value
  typedef enum logic [1:0] {
    ALU_ADD  = 2'd0,
    ALU_SUB  = 2'd1,
    ALU_MUL  = 2'd2,
    ALU_PASS = 2'd3
  } alu_op_t;

endpackage

/* verilog/fetch_control.sv */
`timescale 1ns/1ps

module fetch_control #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic                 CLK,
  input  logic                 resetn,
  input  logic                 halt,
  input  logic                 fetch_valid,
  input  core_pkg::instr_t     instr_fetch,
  input  logic [31:0]          next_pc,
  input  logic                 alu_ready,
  input  logic                 we_request,
  output logic                 fetch_enable,
  output logic [31:0]          fetch_addr,
  output core_pkg::instr_t     issue_instr,
  output logic                 issue_valid,
  output logic [31:0]          issue_pc,
  output logic                 rf_we,
  output logic                 retire
);
  import core_pkg::*;

  // instruction buffer
  instr_t      buf_instr;
  logic        buf_valid;

  // executed flag, low while an issued instr is stalled
  logic        executed;
  logic        executed_reg;

  // fetch bookkeeping
  logic        req_pending;
  logic        fetch_armed;

  // pc of issued instr and address of last fetch
  logic [31:0] pc_reg;
  logic [31:0] next_pc_reg;

  logic        avail;
  logic        new_instr;
  logic        stall;
  logic        done;

  // an instruction is at hand, either arriving or held
  assign avail = fetch_valid | buf_valid;

  // issue only when the previous one has executed
  // halt blocks the issue, not the completion
  assign new_instr = executed_reg & avail & !halt;

  // stalled instr keeps issue_valid up through the buffer
  assign issue_valid = !executed_reg | new_instr;

  // arriving word goes straight out, held word from buffer
  assign issue_instr = buf_valid ? buf_instr : instr_fetch;

  // busy execute unit stalls the issued instr
  assign stall = issue_valid & !alu_ready;
  assign done  = issue_valid & alu_ready;

  always_comb begin
    executed = executed_reg;
    if (issue_valid) begin
      executed = !stall;
    end
  end

  // new fetch once the slot frees up and nothing is outstanding
  // memory answer and next request may share a cycle
  assign fetch_enable = fetch_armed & (!req_pending | fetch_valid) & (!avail | done);

  // branch/jump target comes from exec unit in the retire cycle
  assign fetch_addr = done ? next_pc : next_pc_reg;

  // issued instr takes the address it was fetched from
  assign issue_pc = new_instr ? next_pc_reg : pc_reg;

  // register write and retire masked by the stall
  assign rf_we  = done & we_request;
  assign retire = done;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      executed_reg <= 1'b1;
      buf_valid    <= 1'b0;
      req_pending  <= 1'b0;
      fetch_armed  <= 1'b0;
    end else begin
      executed_reg <= executed;
      // first request one cycle after reset release
      fetch_armed  <= 1'b1;
      // held until it completes
      buf_valid    <= avail & !done;
      // answer clears, new request sets
      if (fetch_enable) begin
        req_pending <= 1'b1;
      end else if (fetch_valid) begin
        req_pending <= 1'b0;
      end
    end
  end

  // capture the arriving word, buffer is empty by then
  always_ff @(posedge CLK) begin
    if (fetch_valid && !buf_valid) begin
      buf_instr <= instr_fetch;
    end
  end

  // pc pair, pc_reg starts one word before the first fetch
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      pc_reg      <= RESET_PC - 32'd4;
      next_pc_reg <= RESET_PC;
    end else begin
      pc_reg      <= issue_pc;
      next_pc_reg <= fetch_addr;
    end
  end

endmodule

/* verilog/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
  input  core_pkg::instr_t  issue_instr,
  output logic [4:0]        rs1_addr,
  output logic [4:0]        rs2_addr,
  output logic [4:0]        rd_addr,
  output logic [31:0]       imm,
  output core_pkg::alu_op_t alu_op,
  output logic              use_imm,
  output logic              is_branch,
  output logic              is_jump,
  output logic              writes_rd
);
  import core_pkg::*;

  always_comb begin
    // defaults give a no-op
    rs1_addr  = 5'd0;
    rs2_addr  = 5'd0;
    rd_addr   = 5'd0;
    imm       = 32'd0;
    alu_op    = ALU_ADD;
    use_imm   = 1'b0;
    is_branch = 1'b0;
    is_jump   = 1'b0;
    writes_rd = 1'b0;

    case (issue_instr.r.opcode)
      OPC_OP: begin
        rs1_addr  = issue_instr.r.rs1;
        rs2_addr  = issue_instr.r.rs2;
        rd_addr   = issue_instr.r.rd;
        writes_rd = 1'b1;
        // funct7 splits add, sub and mul
        case (issue_instr.r.funct7)
          F7_SUB:  alu_op = ALU_SUB;
          F7_MUL:  alu_op = ALU_MUL;
          default: alu_op = ALU_ADD;
        endcase
      end

      OPC_OP_IMM: begin
        rs1_addr  = issue_instr.i.rs1;
        rd_addr   = issue_instr.i.rd;
        imm       = {{20{issue_instr.i.imm_11_0[11]}}, issue_instr.i.imm_11_0};
        use_imm   = 1'b1;
        writes_rd = 1'b1;
      end

      OPC_BRANCH: begin
        // beq only, equality tested in the exec unit
        rs1_addr  = issue_instr.b.rs1;
        rs2_addr  = issue_instr.b.rs2;
        imm       = {{19{issue_instr.b.imm_12}}, issue_instr.b.imm_12,
                     issue_instr.b.imm_11, issue_instr.b.imm_10_5,
                     issue_instr.b.imm_4_1, 1'b0};
        is_branch = 1'b1;
      end

      OPC_JAL: begin
        rd_addr   = issue_instr.j.rd;
        imm       = {{11{issue_instr.j.imm_20}}, issue_instr.j.imm_20,
                     issue_instr.j.imm_19_12, issue_instr.j.imm_11,
                     issue_instr.j.imm_10_1, 1'b0};
        // link value pc+4 passes through
        alu_op    = ALU_PASS;
        is_jump   = 1'b1;
        writes_rd = 1'b1;
      end

      default: begin
        // unknown opcode, nothing written
        writes_rd = 1'b0;
      end
    endcase
  end

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
  input  logic        CLK,
  input  logic        resetn,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  input  logic        we,
  input  logic [4:0]  wd_addr,
  input  logic [31:0] wd_data,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data
);

  // x1..x31, x0 has no storage
  logic [31:0] regs [1:31];

  // combinational reads, x0 forced to zero
  assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      for (int k = 1; k < 32; k++) begin
        regs[k] <= 32'd0;
      end
    end else begin
      // writes to x0 dropped
      if (we && (wd_addr != 5'd0)) begin
        regs[wd_addr] <= wd_data;
      end
    end
  end

endmodule

/* verilog/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit #(
  parameter int MUL_CYCLES = 32
) (
  input  logic              CLK,
  input  logic              resetn,
  input  logic              issue_valid,
  input  logic [31:0]       issue_pc,
  input  logic [31:0]       rs1_data,
  input  logic [31:0]       rs2_data,
  input  logic [31:0]       imm,
  input  core_pkg::alu_op_t alu_op,
  input  logic              use_imm,
  input  logic              is_branch,
  input  logic              is_jump,
  output logic [31:0]       alu_result,
  output logic              alu_ready,
  output logic [31:0]       next_pc
);
  import core_pkg::*;

  // multiplier bits consumed per iteration
  localparam int STEP  = (32 + MUL_CYCLES - 1) / MUL_CYCLES;
  localparam int CNT_W = $clog2(MUL_CYCLES + 1);

  logic [31:0]      op_b;
  logic [31:0]      pc_plus4;
  logic             branch_taken;
  logic             mul_req;
  logic             mul_start;
  logic             mul_busy;
  logic             mul_done;
  logic [CNT_W-1:0] mul_count;
  logic [31:0]      mul_acc;
  logic [31:0]      mul_mcand;
  logic [31:0]      mul_mplier;

  // one shift-add iteration over STEP multiplier bits
  function automatic logic [31:0] partial_sum(input logic [31:0] acc_in,
                                              input logic [31:0] a,
                                              input logic [31:0] b);
    logic [31:0] sum;
    sum = acc_in;
    for (int k = 0; k < STEP; k++) begin
      if (b[k]) begin
        sum = sum + (a << k);
      end
    end
    return sum;
  endfunction

  assign op_b     = use_imm ? imm : rs2_data;
  assign pc_plus4 = issue_pc + 32'd4;

  // jal always, beq on equal operands
  assign branch_taken = is_jump | (is_branch & (rs1_data == rs2_data));
  assign next_pc      = branch_taken ? (issue_pc + imm) : pc_plus4;

  // first iteration happens in the issue cycle
  assign mul_req   = issue_valid & (alu_op == ALU_MUL);
  assign mul_start = mul_req & !mul_busy & !mul_done;

  // low from issue until the product is final
  assign alu_ready = !mul_req | mul_done;

  always_comb begin
    case (alu_op)
      ALU_ADD:  alu_result = rs1_data + op_b;
      ALU_SUB:  alu_result = rs1_data - op_b;
      ALU_MUL:  alu_result = mul_acc;
      ALU_PASS: alu_result = pc_plus4;
      default:  alu_result = 32'd0;
    endcase
  end

  // iteration counter and status
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      mul_busy  <= 1'b0;
      mul_done  <= 1'b0;
      mul_count <= '0;
    end else begin
      // done lasts one cycle, the retire cycle
      mul_done <= 1'b0;
      if (mul_start) begin
        mul_busy  <= (MUL_CYCLES > 1);
        mul_done  <= (MUL_CYCLES == 1);
        mul_count <= CNT_W'(1);
      end else if (mul_busy) begin
        mul_count <= mul_count + CNT_W'(1);
        if (mul_count == CNT_W'(MUL_CYCLES - 1)) begin
          mul_busy <= 1'b0;
          mul_done <= 1'b1;
        end
      end
    end
  end

  // product datapath, operands latched at start
  always_ff @(posedge CLK) begin
    if (mul_start) begin
      mul_acc    <= partial_sum(32'd0, rs1_data, rs2_data);
      mul_mcand  <= rs1_data << STEP;
      mul_mplier <= rs2_data >> STEP;
    end else if (mul_busy) begin
      mul_acc    <= partial_sum(mul_acc, mul_mcand, mul_mplier);
      mul_mcand  <= mul_mcand << STEP;
      mul_mplier <= mul_mplier >> STEP;
    end
  end

endmodule

/* verilog/mini_core.sv */
`timescale 1ns/1ps

module mini_core #(
  parameter logic [31:0] RESET_PC   = 32'h0000_0000,
  parameter int          MUL_CYCLES = 32
) (
  input  logic        CLK,
  input  logic        resetn,
  input  logic        halt,
  input  logic        imem_valid,
  input  logic [31:0] imem_rdata,
  output logic        imem_req,
  output logic [31:0] imem_addr,
  output logic        retire_valid,
  output logic [31:0] retire_pc,
  output logic        wb_en,
  output logic [4:0]  wb_addr,
  output logic [31:0] wb_data
);
  import core_pkg::*;

  // issue path
  instr_t      issue_instr;
  logic        issue_valid;

  // decoded fields
  logic [4:0]  rs1_addr;
  logic [4:0]  rs2_addr;
  logic [31:0] imm;
  alu_op_t     alu_op;
  logic        use_imm;
  logic        is_branch;
  logic        is_jump;
  logic        writes_rd;

  // operands and execute feedback
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic        alu_ready;
  logic [31:0] next_pc;

  // retire signals double as the register write port
  fetch_control #(
    .RESET_PC (RESET_PC)
  ) u_fetch_control (
    .CLK          (CLK),
    .resetn       (resetn),
    .halt         (halt),
    .fetch_valid  (imem_valid),
    .instr_fetch  (imem_rdata),
    .next_pc      (next_pc),
    .alu_ready    (alu_ready),
    .we_request   (writes_rd),
    .fetch_enable (imem_req),
    .fetch_addr   (imem_addr),
    .issue_instr  (issue_instr),
    .issue_valid  (issue_valid),
    .issue_pc     (retire_pc),
    .rf_we        (wb_en),
    .retire       (retire_valid)
  );

  instr_decoder u_instr_decoder (
    .issue_instr (issue_instr),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rd_addr     (wb_addr),
    .imm         (imm),
    .alu_op      (alu_op),
    .use_imm     (use_imm),
    .is_branch   (is_branch),
    .is_jump     (is_jump),
    .writes_rd   (writes_rd)
  );

  reg_file u_reg_file (
    .CLK      (CLK),
    .resetn   (resetn),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .we       (wb_en),
    .wd_addr  (wb_addr),
    .wd_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  exec_unit #(
    .MUL_CYCLES (MUL_CYCLES)
  ) u_exec_unit (
    .CLK         (CLK),
    .resetn      (resetn),
    .issue_valid (issue_valid),
    .issue_pc    (retire_pc),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .alu_op      (alu_op),
    .use_imm     (use_imm),
    .is_branch   (is_branch),
    .is_jump     (is_jump),
    .alu_result  (wb_data),
    .alu_ready   (alu_ready),
    .next_pc     (next_pc)
  );

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int RESET_CYCLES = 16
) (
  output logic CLK,
  output logic resetn
);

  // 10 ns period
  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // reset held for RESET_CYCLES rising edges, released on a falling edge
  initial begin
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    resetn = 1'b1;
  end

endmodule

/* dv/tb_mini_core.sv */
`timescale 1ns/1ps

module tb_mini_core;
  import core_pkg::*;

  localparam logic [31:0] RESET_PC      = 32'h0000_0080;
  localparam int          MUL_CYCLES    = 32;
  localparam int          RESET_CYCLES  = 16;
  // words put in memory over all programs, skipped ones included
  localparam int          PROGRAM_WORDS = 59;
  localparam int          CYCLE_LIMIT   = PROGRAM_WORDS * (3 + MUL_CYCLES) + RESET_CYCLES;

  logic        CLK;
  logic        resetn;
  logic        halt;
  logic        imem_valid;
  logic [31:0] imem_rdata;
  logic        imem_req;
  logic [31:0] imem_addr;
  logic        retire_valid;
  logic [31:0] retire_pc;
  logic        wb_en;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;

  // instruction memory, answered only below mem_top
  logic [31:0] mem [0:1023];
  logic [9:0]  mem_top;
  logic        mem_pending;
  logic [31:0] mem_addr_q;
  int          mem_wait;

  // reference model
  logic [31:0] mregs [0:31];
  logic [31:0] mpc;

  // word answered but not yet retired, and its issue cycle
  logic        halt_req;
  logic        in_hand;
  logic        issued;
  int          issue_cycle;
  int          cycle_count;
  int          retired;
  int          requests;
  int          answers;
  logic [31:0] rng;

  tb_clock #(
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clock (
    .CLK    (CLK),
    .resetn (resetn)
  );

  mini_core #(
    .RESET_PC   (RESET_PC),
    .MUL_CYCLES (MUL_CYCLES)
  ) u_dut (
    .CLK          (CLK),
    .resetn       (resetn),
    .halt         (halt),
    .imem_valid   (imem_valid),
    .imem_rdata   (imem_rdata),
    .imem_req     (imem_req),
    .imem_addr    (imem_addr),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .wb_en        (wb_en),
    .wb_addr      (wb_addr),
    .wb_data      (wb_data)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic word_check(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED at %0t: %s expected %08h actual %08h",
                          $time, name, expected, actual));
    end
  endtask

  task automatic addr_check(input string name, input logic [4:0] expected,
                            input logic [4:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED at %0t: %s expected x%0d actual x%0d",
                          $time, name, expected, actual));
    end
  endtask

  task automatic instr_check(input string name, input instr_t expected, input instr_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED at %0t: %s expected %08h actual %08h",
                          $time, name, expected, actual));
    end
  endtask

  task automatic flag_check(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED at %0t: %s expected %b actual %b",
                          $time, name, expected, actual));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // encoders, field order as in the ISA manual
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, 3'b000, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] beq_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  task automatic put_word(input logic [31:0] word);
    mem[mem_top] = word;
    mem_top      = mem_top + 10'd1;
  endtask

  // model executes the word at mpc and compares the retire ports
  task automatic score_retire();
    logic [31:0] word;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic [31:0] target;
    logic        we;
    int          lat;
    word   = mem[mpc[11:2]];
    a      = mregs[word[19:15]];
    b      = mregs[word[24:20]];
    val    = 32'd0;
    we     = 1'b0;
    lat    = 0;
    target = mpc + 32'd4;
    if (!issued) begin
      abort_run("an instruction retired that was never issued");
    end
    instr_check("issue_instr", word, u_dut.issue_instr);
    word_check("retire_pc", mpc, retire_pc);
    case (word[6:0])
      OPC_OP_IMM: begin
        we  = 1'b1;
        val = a + {{20{word[31]}}, word[31:20]};
      end
      OPC_OP: begin
        we = 1'b1;
        if (word[31:25] == F7_SUB) begin
          val = a - b;
        end else if (word[31:25] == F7_MUL) begin
          // low half of the product, MUL_CYCLES of stall
          val = a * b;
          lat = MUL_CYCLES;
        end else begin
          val = a + b;
        end
      end
      OPC_BRANCH: begin
        if (a == b) begin
          target = mpc + {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        end
      end
      OPC_JAL: begin
        we     = 1'b1;
        val    = mpc + 32'd4;
        target = mpc + {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
      end
      default: begin
        we = 1'b0;
      end
    endcase
    flag_check("wb_en", we, wb_en);
    if (we) begin
      addr_check("wb_addr", word[11:7], wb_addr);
      word_check("wb_data", val, wb_data);
      // x0 keeps zero
      if (word[11:7] != 5'd0) begin
        mregs[word[11:7]] = val;
      end
    end
    word_check("issue-to-retire cycles", 32'(lat), 32'(cycle_count - issue_cycle));
    // next fetch goes out in the retire cycle
    flag_check("imem_req", 1'b1, imem_req);
    mpc     = target;
    in_hand = 1'b0;
    issued  = 1'b0;
    retired++;
  endtask

  task automatic take_request();
    if (mem_pending) begin
      abort_run("the core sent a second fetch request while one was pending");
    end
    if (in_hand) begin
      abort_run("the core sent a fetch request while an instruction was outstanding");
    end
    // next fetch follows the model pc, target included
    word_check("imem_addr", mpc, imem_addr);
    mem_pending = 1'b1;
    mem_addr_q  = imem_addr;
    // latency 1 to 3 cycles
    mem_wait    = int'(next_random() % 32'd3);
    requests++;
  endtask

  // one clock, inputs on the falling edge, outputs read 2 ns later
  task automatic next_cycle();
    @(negedge CLK);
    halt       = halt_req;
    imem_valid = 1'b0;
    imem_rdata = 32'd0;
    if (mem_pending && mem_wait > 0) begin
      mem_wait = mem_wait - 1;
    end else if (mem_pending && mem_addr_q[11:2] < mem_top) begin
      imem_valid  = 1'b1;
      imem_rdata  = mem[mem_addr_q[11:2]];
      mem_pending = 1'b0;
      in_hand     = 1'b1;
      answers++;
    end
    #2;
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      abort_run("timeout, the programs did not finish within the cycle limit");
    end
    // issue happens once the word is in hand and halt is low
    if (in_hand && !issued && !halt) begin
      issued      = 1'b1;
      issue_cycle = cycle_count;
    end
    if (retire_valid) begin
      score_retire();
    end
    if (imem_req) begin
      take_request();
    end
  endtask

  task automatic run_until_retired(input int target);
    while (retired < target) begin
      next_cycle();
    end
  endtask

  task automatic reset_and_first_fetch();
    int waited;
    waited = 0;
    while (!resetn) begin
      next_cycle();
      if (!resetn) begin
        flag_check("imem_req", 1'b0, imem_req);
        flag_check("retire_valid", 1'b0, retire_valid);
        flag_check("wb_en", 1'b0, wb_en);
      end
    end
    // first address is checked against mpc, which is RESET_PC
    // request due in the first cycle out of reset
    while (requests == 0) begin
      next_cycle();
      waited++;
      if (waited > 1) begin
        abort_run("the first fetch request did not come in the first cycle after reset");
      end
    end
  endtask

  task automatic arithmetic_seq();
    int base;
    base = retired;
    put_word(i_type(5'd1, 5'd0, 12'd5));
    put_word(i_type(5'd2, 5'd0, 12'hffd));
    put_word(r_type(7'd0, 5'd3, 5'd1, 5'd2));
    put_word(r_type(F7_SUB, 5'd4, 5'd1, 5'd2));
    // write to x0, then read x0 back
    put_word(i_type(5'd0, 5'd1, 12'd7));
    put_word(r_type(7'd0, 5'd5, 5'd0, 5'd1));
    run_until_retired(base + 6);
  endtask

  task automatic multiply_stall();
    int base;
    base = retired;
    put_word(i_type(5'd6, 5'd0, 12'h4d2));
    put_word(i_type(5'd7, 5'd0, 12'hfb3));
    put_word(r_type(F7_MUL, 5'd8, 5'd6, 5'd7));
    // product of a product, upper bits dropped
    put_word(r_type(F7_MUL, 5'd9, 5'd8, 5'd8));
    run_until_retired(base + 4);
  endtask

  task automatic branch_and_jump();
    int base;
    base = retired;
    put_word(i_type(5'd10, 5'd0, 12'd9));
    put_word(i_type(5'd11, 5'd0, 12'd9));
    // taken, skips the next word
    put_word(beq_word(5'd10, 5'd11, 13'd8));
    put_word(i_type(5'd31, 5'd0, 12'hfff));
    // x1 holds 5, not taken
    put_word(beq_word(5'd10, 5'd1, 13'd8));
    put_word(jal_word(5'd12, 21'd8));
    put_word(i_type(5'd31, 5'd0, 12'hfff));
    // link value read back
    put_word(r_type(7'd0, 5'd13, 5'd12, 5'd0));
    run_until_retired(base + 6);
  endtask

  task automatic halt_hold();
    int base;
    int base_answers;
    base         = retired;
    base_answers = answers;
    halt_req     = 1'b1;
    put_word(i_type(5'd14, 5'd1, 12'd100));
    repeat (10) begin
      next_cycle();
      flag_check("retire_valid", 1'b0, retire_valid);
    end
    flag_check("imem_valid seen under halt", 1'b1, answers > base_answers);
    halt_req = 1'b0;
    run_until_retired(base + 1);
  endtask

  task automatic random_program();
    logic [31:0] r;
    int          base;
    base = retired;
    for (int n = 0; n < 40; n++) begin
      r = next_random();
      // registers x0..x7 only, so results feed each other
      case (r[10:9])
        2'd0:    put_word(i_type({2'b00, r[2:0]}, {2'b00, r[5:3]}, r[22:11]));
        2'd1:    put_word(r_type(7'd0, {2'b00, r[2:0]}, {2'b00, r[5:3]}, {2'b00, r[8:6]}));
        2'd2:    put_word(r_type(F7_SUB, {2'b00, r[2:0]}, {2'b00, r[5:3]}, {2'b00, r[8:6]}));
        default: put_word(r_type(F7_MUL, {2'b00, r[2:0]}, {2'b00, r[5:3]}, {2'b00, r[8:6]}));
      endcase
    end
    run_until_retired(base + 40);
  endtask

  initial begin
    halt        = 1'b0;
    halt_req    = 1'b0;
    imem_valid  = 1'b0;
    imem_rdata  = 32'd0;
    mem_top     = RESET_PC[11:2];
    mem_pending = 1'b0;
    mem_addr_q  = 32'd0;
    mem_wait    = 0;
    mpc         = RESET_PC;
    in_hand     = 1'b0;
    issued      = 1'b0;
    issue_cycle = 0;
    cycle_count = 0;
    retired     = 0;
    requests    = 0;
    answers     = 0;
    rng         = 32'hafca5378;
    // fill follows the byte address
    for (int k = 0; k < 1024; k++) begin
      mem[k[9:0]] = 32'hc0de_0000 ^ (32'(k) << 2);
    end
    for (int k = 0; k < 32; k++) begin
      mregs[k[4:0]] = 32'd0;
    end

    reset_and_first_fetch();
    arithmetic_seq();
    multiply_stall();
    branch_and_jump();
    halt_hold();
    random_program();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* src.f */
verilog/core_pkg.sv
verilog/fetch_control.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/mini_core.sv
dv/tb_clock.sv
dv/tb_mini_core.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --timescale 1ns/1ps -j 0
TOP       := tb_mini_core
FILELIST  := src.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the verdict
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
